// ==== emesh_regs.f ====
+incdir+rtl
rtl/emesh_pkg.sv
rtl/emesh_regfile.sv
rtl/emesh_readback.sv
rtl/emesh_regs.sv
test/emesh_regs_tb.sv

// ==== rtl/emesh_config.svh ====
`ifndef EMESH_CONFIG_SVH
`define EMESH_CONFIG_SVH

// ################################################
// mesh geometry
// ################################################

`define EMESH_AW 32                   // address and data width
`define EMESH_PW (2*`EMESH_AW+40)     // packet width, 104 bits

// ################################################
// register window
// ################################################

`define EMESH_REG_COUNT 16            // number of 32-bit registers

// window base address
// must be aligned to the window size (4 bytes per register)
`define EMESH_REG_BASE 32'h0008_0000

`endif

// ==== rtl/emesh_pkg.sv ====
`include "emesh_config.svh"

package emesh_pkg;

   // ################################################
   // basic types
   // ################################################

   typedef logic [`EMESH_AW-1:0] word_t;   // one mesh address or data word

   // access size of a transaction
   typedef enum logic [1:0]
   {
      dm_byte   = 2'b00,   // 8 bit
      dm_half   = 2'b01,   // 16 bit
      dm_word   = 2'b10,   // 32 bit
      dm_double = 2'b11    // 64 bit, upper word rides in srcaddr
   } datamode_t;

   // ################################################
   // mesh packet
   // ################################################

   // field order follows the mesh wire format, msb first
   typedef struct packed
   {
      word_t     srcaddr;   // return address or upper data word
      word_t     data;      // lower data word
      word_t     dstaddr;   // target address
      logic [4:0] ctrlmode; // carried through untouched
      datamode_t datamode;  // access size
      logic      write;     // 1 = write, 0 = read
   } emesh_packet_t;

   // ################################################
   // register bank addressing
   // ################################################

   // bits needed to pick one register
   localparam int REG_IDX_W = $clog2(`EMESH_REG_COUNT);

   typedef logic [REG_IDX_W-1:0] reg_index_t;

   // byte offset of the lowest address bit above the register index
   localparam int REG_WIN_LSB = REG_IDX_W + 2;

endpackage

// ==== rtl/emesh_readback.sv ====
module emesh_readback
   import emesh_pkg::*;
(
   input  logic          clk,          // clock
   input  logic          nreset,       // async reset, active low
   input  logic          access_in,    // packet strobe
   input  emesh_packet_t packet_in,    // incoming packet
   input  logic [63:0]   read_data,    // pipelined data from the bank
   input  logic          wait_in,      // stall from downstream mesh
   output logic          wait_out,     // stall back to the sender
   output logic          access_out,   // return packet strobe
   output emesh_packet_t packet_out    // return write packet
);

   // ################################################
   // accept
   // ################################################

   logic rd_accept;   // read taken at this edge

   // only reads create a return, and only when not stalled
   assign rd_accept = access_in & ~packet_in.write & ~wait_in;

   // ################################################
   // return pipeline
   // ################################################

   datamode_t  datamode_q;   // size of the read
   logic [4:0] ctrlmode_q;   // ctrlmode passes through
   word_t      dstaddr_q;    // where the data goes back to

   // strobe follows accepted reads, holds under wait
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         access_out <= 1'b0;
      end
      else if (!wait_in)
      begin
         access_out <= access_in & ~packet_in.write;
      end
   end

   // routing fields, loaded only for accepted reads
   always_ff @(posedge clk)
   begin
      if (rd_accept)
      begin
         datamode_q <= packet_in.datamode;
         ctrlmode_q <= packet_in.ctrlmode;
         dstaddr_q  <= packet_in.srcaddr;   // swap src into dst
      end
   end

   // back-pressure is not buffered here
   assign wait_out = wait_in;

   // ################################################
   // build return packet
   // ################################################

   // the return is always a write to the reader
   always_comb
   begin
      packet_out.write    = 1'b1;
      packet_out.datamode = datamode_q;
      packet_out.ctrlmode = ctrlmode_q;
      packet_out.dstaddr  = dstaddr_q;
      packet_out.data     = read_data[31:0];    // low word
      packet_out.srcaddr  = read_data[63:32];   // high word or echoed address
   end

endmodule

// ==== rtl/emesh_regfile.sv ====
`include "emesh_config.svh"

module emesh_regfile
   import emesh_pkg::*;
(
   input  logic          clk,         // clock
   input  logic          nreset,      // async reset, active low
   input  logic          access_in,   // packet strobe
   input  emesh_packet_t packet_in,   // incoming packet
   input  logic          wait_in,     // stall from downstream mesh
   output logic [63:0]   read_data    // pipelined read word
);

   // window base as a vector so it can be sliced
   localparam word_t REG_BASE = `EMESH_REG_BASE;

   // ################################################
   // storage and decode
   // ################################################

   word_t      regs [`EMESH_REG_COUNT];   // the register bank

   logic       win_hit;    // dstaddr falls inside the window
   reg_index_t idx;        // addressed register
   reg_index_t idx_even;   // even half of a double pair
   reg_index_t idx_odd;    // odd half of a double pair
   logic       wr_en;      // write accepted this edge
   word_t      wr_word;    // merged value for single writes
   logic [1:0] lane;       // byte lane within the word

   // window compare on the bits above the register index
   assign win_hit = (packet_in.dstaddr[`EMESH_AW-1:REG_WIN_LSB] ==
                     REG_BASE[`EMESH_AW-1:REG_WIN_LSB]);

   // word address bits pick the register
   assign idx      = packet_in.dstaddr[REG_WIN_LSB-1:2];
   assign idx_even = {idx[REG_IDX_W-1:1], 1'b0};
   assign idx_odd  = {idx[REG_IDX_W-1:1], 1'b1};
   assign lane     = packet_in.dstaddr[1:0];

   // only unstalled writes inside the window land
   assign wr_en = access_in & packet_in.write & ~wait_in & win_hit;

   // ################################################
   // write merge
   // ################################################

   // start from the old contents and patch the addressed lane
   always_comb
   begin
      wr_word = regs[idx];
      case (packet_in.datamode)
         dm_byte:
         begin
            wr_word[8*lane +: 8] = packet_in.data[7:0];     // one byte lane
         end
         dm_half:
         begin
            wr_word[16*lane[1] +: 16] = packet_in.data[15:0]; // upper or lower half
         end
         default:
         begin
            wr_word = packet_in.data;   // word, double low half
         end
      endcase
   end

   // bank update, doubles touch the even/odd pair
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < `EMESH_REG_COUNT; i++)
         begin
            regs[i] <= '0;   // bank comes up cleared
         end
      end
      else if (wr_en)
      begin
         if (packet_in.datamode == dm_double)
         begin
            regs[idx_even] <= packet_in.data;      // low word
            regs[idx_odd]  <= packet_in.srcaddr;   // high word
         end
         else
         begin
            regs[idx] <= wr_word;
         end
      end
   end

   // ################################################
   // read port
   // ################################################

   word_t rd_lo;   // next low word
   word_t rd_hi;   // next high word

   // pick the words for whatever packet sits on the input
   always_comb
   begin
      if (!win_hit)
      begin
         rd_lo = '0;   // outside window reads as zero
         rd_hi = '0;
      end
      else if (packet_in.datamode == dm_double)
      begin
         rd_lo = regs[idx_even];
         rd_hi = regs[idx_odd];
      end
      else
      begin
         rd_lo = regs[idx];
         rd_hi = packet_in.dstaddr;   // echo the address back
      end
   end

   // one stage, lines up with the readback return fields
   // a write at the previous edge is already in regs here
   always_ff @(posedge clk)
   begin
      if (!wait_in)
      begin
         read_data <= {rd_hi, rd_lo};
      end
   end

endmodule

// ==== rtl/emesh_regs.sv ====
module emesh_regs
   import emesh_pkg::*;
(
   input  logic          clk,          // clock
   input  logic          nreset,       // async reset, active low

   // mesh input side
   input  logic          access_in,    // packet strobe
   input  emesh_packet_t packet_in,    // read or write packet
   output logic          wait_out,     // stall toward the sender

   // mesh return side
   output logic          access_out,   // return strobe
   output emesh_packet_t packet_out,   // return write packet
   input  logic          wait_in       // stall from downstream
);

   // ################################################
   // internal wiring
   // ################################################

   logic [63:0] read_data;   // bank to readback, one cycle after the read

   // ################################################
   // register bank
   // ################################################

   // handles writes, produces the read word for every packet
   emesh_regfile regs0
   (
      .clk       (clk),
      .nreset    (nreset),
      .access_in (access_in),
      .packet_in (packet_in),
      .wait_in   (wait_in),
      .read_data (read_data)
   );

   // ################################################
   // read return path
   // ################################################

   // turns reads into write packets back to the source
   emesh_readback rb0
   (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .read_data  (read_data),
      .wait_in    (wait_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the emesh_regs testbench with Verilator
# exit status is nonzero when the testbench hits $fatal
set -e

cd "$(dirname "$0")"

# rtl files carry no timescale, give them the testbench units
verilator --binary --timing \
   --timescale 1ns/100ps \
   -f emesh_regs.f \
   --top-module emesh_regs_tb \
   -Mdir obj_dir \
   -o emesh_regs_sim

# golden file path is relative to the project root
./obj_dir/emesh_regs_sim

// ==== test/emesh_regs_golden.txt ====
// kind wr dm cm dstaddr  srcaddr  data     exp_dst  exp_data exp_src
// kind 0 normal gap, 1 no gap, 2 random stalls, f end; all hex
// word writes then reads
0 1 2 00 00080000 00000000 11111111 00000000 00000000 00000000
0 1 2 00 00080004 00000000 22222222 00000000 00000000 00000000
0 1 2 01 00080008 00000000 33333333 00000000 00000000 00000000
0 1 2 02 0008000c 00000000 44444444 00000000 00000000 00000000
0 0 2 03 00080000 00a00010 00000000 00a00010 11111111 00080000
0 0 2 03 00080004 00a00014 00000000 00a00014 22222222 00080004
0 0 2 00 00080008 00a00018 00000000 00a00018 33333333 00080008
0 0 2 04 0008000c 00a0001c 00000000 00a0001c 44444444 0008000c
// byte and half lane merges
0 1 2 00 00080010 00000000 aabbccdd 00000000 00000000 00000000
0 1 0 00 00080011 00000000 00000055 00000000 00000000 00000000
0 1 0 00 00080013 00000000 000000e7 00000000 00000000 00000000
0 0 2 00 00080010 00a00020 00000000 00a00020 e7bb55dd 00080010
0 1 2 00 00080014 00000000 12345678 00000000 00000000 00000000
0 1 1 00 00080016 00000000 0000beef 00000000 00000000 00000000
0 1 1 00 00080014 00000000 ffff0abc 00000000 00000000 00000000
0 0 2 00 00080014 00a00024 00000000 00a00024 beef0abc 00080014
0 1 0 00 00080018 00000000 12345699 00000000 00000000 00000000
0 0 2 00 00080018 00a00028 00000000 00a00028 00000099 00080018
// double writes and reads
0 1 3 00 00080020 cafe0009 beef0008 00000000 00000000 00000000
0 0 3 00 00080020 00b00000 00000000 00b00000 beef0008 cafe0009
0 0 3 06 00080024 00b00004 00000000 00b00004 beef0008 cafe0009
0 1 3 00 0008002c 0b0b0b0b 0a0a0a0a 00000000 00000000 00000000
0 0 2 00 00080028 00b00008 00000000 00b00008 0a0a0a0a 00080028
0 0 2 00 0008002c 00b0000c 00000000 00b0000c 0b0b0b0b 0008002c
// outside the register window
0 1 2 00 00090000 00000000 deadbeef 00000000 00000000 00000000
0 1 2 00 00080040 00000000 5a5a5a5a 00000000 00000000 00000000
0 0 2 00 00090000 00b00010 00000000 00b00010 00000000 00000000
0 0 2 00 00080040 00b00014 00000000 00b00014 00000000 00000000
0 0 3 00 00100000 00b00018 00000000 00b00018 00000000 00000000
0 0 2 00 00080000 00b0001c 00000000 00b0001c 11111111 00080000
// back to back, mixed ctrlmode and datamode
0 0 0 1f 00080000 00d00000 00000000 00d00000 11111111 00080000
1 0 1 0a 00080004 00d00004 00000000 00d00004 22222222 00080004
1 0 3 15 00080008 00d00008 00000000 00d00008 33333333 44444444
1 1 2 07 0008001c 00000000 77777777 00000000 00000000 00000000
1 0 2 00 0008001c 00d0000c 00000000 00d0000c 77777777 0008001c
1 0 2 1e 0008000c 00d00010 00000000 00d00010 44444444 0008000c
1 1 2 00 00080038 00000000 38383838 00000000 00000000 00000000
1 1 2 00 0008003c 00000000 3c3c3c3c 00000000 00000000 00000000
1 0 3 09 00080038 00d00014 00000000 00d00014 38383838 3c3c3c3c
// random wait_in stalls
2 1 2 00 00080030 00000000 c0c0c0c0 00000000 00000000 00000000
2 0 2 00 00080030 00c00000 00000000 00c00000 c0c0c0c0 00080030
2 1 2 00 00080034 00000000 d1d2d3d4 00000000 00000000 00000000
2 1 0 00 00080036 00000000 0000007e 00000000 00000000 00000000
2 0 2 00 00080034 00c00004 00000000 00c00004 d17ed3d4 00080034
2 0 2 11 00080000 00c00008 00000000 00c00008 11111111 00080000
2 0 2 00 00080004 00c0000c 00000000 00c0000c 22222222 00080004
2 0 3 02 00080020 00c00010 00000000 00c00010 beef0008 cafe0009
2 0 2 00 00080010 00c00014 00000000 00c00014 e7bb55dd 00080010
2 0 2 00 00080014 00c00018 00000000 00c00018 beef0abc 00080014
2 0 2 0c 00080018 00c0001c 00000000 00c0001c 00000099 00080018
2 0 2 00 0008001c 00c00020 00000000 00c00020 77777777 0008001c
2 0 2 00 00090004 00c00024 00000000 00c00024 00000000 00000000
2 0 2 00 0008002c 00c00028 00000000 00c00028 0b0b0b0b 0008002c
2 0 2 1b 00080028 00c0002c 00000000 00c0002c 0a0a0a0a 00080028
// end of list
f 0 0 00 00000000 00000000 00000000 00000000 00000000 00000000

// ==== test/emesh_regs_tb.sv ====
module emesh_regs_tb
   import emesh_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   // ################################################
   // golden file layout
   // ################################################

   localparam int MAX_TXN    = 64;   // lines the memory can hold
   localparam int COLS       = 10;   // words per transaction line
   localparam int ACCEPT_MAX = 40;   // stalled cycles before giving up
   localparam int DRAIN_MAX  = 50;   // cycles to wait for the last returns

   localparam int C_KIND  = 0;   // 0 normal, 1 no gap, 2 stalled, f end
   localparam int C_WR    = 1;
   localparam int C_DM    = 2;
   localparam int C_CM    = 3;
   localparam int C_DST   = 4;
   localparam int C_SRC   = 5;
   localparam int C_DATA  = 6;
   localparam int C_XDST  = 7;   // expected return fields
   localparam int C_XDATA = 8;
   localparam int C_XSRC  = 9;

   logic          clk;
   logic          nreset;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_out;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_in;

   logic [31:0]   golden [0:MAX_TXN*COLS-1];
   emesh_packet_t exp_q [$];   // returns still owed, oldest first
   emesh_packet_t ret_exp;     // return being checked
   logic          stall_en;    // random wait_in while high
   logic          exp_access;  // predicted access_out

   always #10 clk = ~clk;   // 20 ns period

   emesh_regs dut0
   (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   // ################################################
   // helpers
   // ################################################

   task automatic compare_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("Error: t=%0t %s is %h, expected %h", $time, name, actual, expected);
         $display("Errors found");
         $fatal(1);
      end
   endtask

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Errors found");
      $fatal(1);
   endtask

   // inputs only change here, on the falling edge
   task automatic next_negedge();
      @(negedge clk);
      if (stall_en)
         wait_in = ($urandom_range(2) == 0);   // about one cycle in three
      else
         wait_in = 1'b0;
   endtask

   // one golden line: idle gap, drive, hold until taken
   task automatic drive_txn(input int base);
      logic [31:0]   kind;
      int            gap;
      int            cnt;
      logic          accepted;
      emesh_packet_t pkt;
      emesh_packet_t ret;
      kind = golden[base+C_KIND];
      gap  = 0;
      case (kind)
         32'h0: gap = $urandom_range(2);
         32'h1: gap = 0;                  // back to back
         32'h2: gap = $urandom_range(3);
         default: abort_run("unknown transaction kind in golden file");
      endcase
      stall_en     = (kind == 32'h2);
      pkt.write    = golden[base+C_WR][0];
      pkt.datamode = datamode_t'(golden[base+C_DM][1:0]);
      pkt.ctrlmode = golden[base+C_CM][4:0];
      pkt.dstaddr  = golden[base+C_DST];
      pkt.srcaddr  = golden[base+C_SRC];
      pkt.data     = golden[base+C_DATA];
      next_negedge();
      if (gap != 0)
      begin
         access_in = 1'b0;
         repeat (gap) next_negedge();
      end
      packet_in = pkt;
      access_in = 1'b1;
      if (!pkt.write)
      begin
         ret.write    = 1'b1;   // returns are always writes
         ret.datamode = pkt.datamode;
         ret.ctrlmode = pkt.ctrlmode;
         ret.dstaddr  = golden[base+C_XDST];
         ret.data     = golden[base+C_XDATA];
         ret.srcaddr  = golden[base+C_XSRC];
         exp_q.push_back(ret);
      end
      accepted = 1'b0;
      cnt      = 0;
      while (!accepted)
      begin
         @(posedge clk);
         if (!wait_out)
            accepted = 1'b1;   // taken at this edge
         else
         begin
            cnt++;
            if (cnt > ACCEPT_MAX)
               abort_run("packet never accepted, wait_out stuck high");
            next_negedge();
         end
      end
   endtask

   // ################################################
   // output monitor
   // ################################################

   // pre-edge values, all settled since the last falling edge
   always @(posedge clk)
   begin
      if (!nreset)
         exp_access = 1'b0;
      else
      begin
         compare_value("wait_out", 32'(wait_out), 32'(wait_in));
         compare_value("access_out", 32'(access_out), 32'(exp_access));
         if (access_out && !wait_in)   // return taken downstream
         begin
            if (exp_q.size() == 0)
               abort_run("return packet arrived with none expected");
            else
            begin
               ret_exp = exp_q.pop_front();
               compare_value("return write", 32'(packet_out.write), 32'(ret_exp.write));
               compare_value("return datamode", 32'(packet_out.datamode),
                             32'(ret_exp.datamode));
               compare_value("return ctrlmode", 32'(packet_out.ctrlmode),
                             32'(ret_exp.ctrlmode));
               compare_value("return dstaddr", packet_out.dstaddr, ret_exp.dstaddr);
               compare_value("return data", packet_out.data, ret_exp.data);
               compare_value("return srcaddr", packet_out.srcaddr, ret_exp.srcaddr);
            end
         end
         if (!wait_in)
            exp_access = access_in & ~packet_in.write;   // strobe one cycle later
      end
   end

   // ################################################
   // main sequence
   // ################################################

   initial
   begin
      int          n;
      int          cnt;
      clk       = 1'b0;
      nreset    = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0;
      stall_en  = 1'b0;
      void'($urandom(36));   // fixed seed for gaps and stalls
      $readmemh("test/emesh_regs_golden.txt", golden);
      repeat (5) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      n = 0;
      while (n < MAX_TXN && golden[n*COLS+C_KIND] !== 32'hf)
      begin
         drive_txn(n*COLS);
         n++;
      end
      if (n == MAX_TXN)
         abort_run("golden file has no end marker");
      stall_en = 1'b0;
      next_negedge();
      access_in = 1'b0;
      cnt = 0;
      while (exp_q.size() != 0 && cnt < DRAIN_MAX)
      begin
         next_negedge();
         cnt++;
      end
      repeat (5) next_negedge();   // room for a stray extra return
      if (exp_q.size() == 0)
      begin
         $display("No errors");
         $finish;
      end
      else
      begin
         $display("%0d return packets never arrived", exp_q.size());
         $display("Errors found");
         $fatal(1);
      end
   end

endmodule
